// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wall
TOP       := cpuCoreTb
FILELIST  := cpuCore.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o simv
	./$(OBJDIR)/simv | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cpuCore.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/issueControl.sv
verilog/mulUnit.sv
verilog/regFile.sv
verilog/execute.sv
verilog/cpuCoreTop.sv
dv/cpuCoreChecker.sv
dv/cpuCoreTb.sv

// File: dv/cpuCoreChecker.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module cpuCoreChecker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic                       issue,
    input  logic [`DATA_WIDTH-1:0]     memDataIn,
    input  logic                       ready,
    input  logic                       regWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
    input  logic [`DATA_WIDTH-1:0]     regWriteData,
    input  logic [3:0]                 flags,
    input  logic                       branchTaken,
    input  logic [`IMM_WIDTH-1:0]      branchOffset,
    input  logic                       memRead,
    input  logic                       memWrite,
    input  logic [`DATA_WIDTH-1:0]     memAddr,
    input  logic [`DATA_WIDTH-1:0]     memDataOut,
    output int                         errorCount
);

    logic [31:0] regs [16];
    logic [31:0] mem [logic [31:0]];   // Only addresses the core has stored to
    logic [3:0]  mFlags;
    logic        busy;
    int          waitCnt;
    logic [3:0]  mulDestM;
    logic        mulSignedM;
    logic [31:0] mulResult;

    initial errorCount = 0;

    // {valid, setFlags, N, Z, C, V, result} from plain arithmetic
    function automatic logic [37:0] refAlu(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      sres;
        logic [32:0] u;
        logic [31:0] r;
        logic        c;
        logic        ok;
        sa = $signed(a);
        sb = $signed(b);
        sres = 0;
        r = '0;
        c = 1'b0;
        ok = 1'b1;
        case (op)
            cpuPkg::ADD, cpuPkg::ADDS: begin
                u = {1'b0, a} + {1'b0, b};
                r = u[31:0];
                c = u[32];
                sres = sa + sb;
            end
            cpuPkg::SUB, cpuPkg::SUBS: begin
                r = a - b;
                c = (a >= b);   // No borrow
                sres = sa - sb;
            end
            cpuPkg::NOT: r = ~a;
            default: ok = 1'b0;
        endcase
        return {ok, (op == cpuPkg::ADDS || op == cpuPkg::SUBS), r[31], (r == 0), c,
                (sres > 64'sd2147483647 || sres < -64'sd2147483648), r};
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic step();
        logic        expWr;
        logic [3:0]  expAddr;
        logic [31:0] expData;
        logic [3:0]  nextFlags;
        logic        expRd;
        logic        expSt;
        logic        expBr;
        logic        isBranch;
        logic [31:0] expMemAddr;
        logic [31:0] immX;
        logic [37:0] alu;
        logic [1:0]  lvl;
        logic [3:0]  op;
        logic [2:0]  fn;
        logic [3:0]  d;
        logic [3:0]  s1;
        logic [3:0]  s2;
        expWr = 0;
        expAddr = 0;
        expData = 0;
        expRd = 0;
        expSt = 0;
        expBr = 0;
        isBranch = 0;
        expMemAddr = 0;
        nextFlags = mFlags;
        lvl = instr[`LEVEL_MSB:`LEVEL_LSB];
        op = instr[`OP_MSB:`OP_LSB];
        fn = instr[`ALUFN_MSB:`ALUFN_LSB];
        d = instr[`DEST_MSB:`DEST_LSB];
        s1 = instr[`SRC1_MSB:`SRC1_LSB];
        s2 = instr[`SRC2_MSB:`SRC2_LSB];
        immX = {{16{instr[15]}}, instr[15:0]};
        compare("ready", {31'b0, ready}, {31'b0, !busy});
        if (busy && waitCnt == 0) begin   // Release cycle
            expWr = 1;
            expAddr = mulDestM;
            expData = mulResult;
            if (mulSignedM)
                nextFlags = mFlags | {mulResult[31], mulResult == 0, 2'b00};
            busy = 0;
        end else if (busy) begin
            waitCnt--;   // Issue here is ignored
        end else if (issue) begin
            case (lvl)
                cpuPkg::DATA_IMM: begin
                    if (!instr[`SPECIAL_BIT]) begin
                        expWr = (fn == cpuPkg::MOV) || (fn == cpuPkg::CLR);
                        expData = (fn == cpuPkg::MOV) ? immX : 32'h0;
                    end else if (op != cpuPkg::NOT) begin
                        alu = refAlu(op, regs[s1], immX);
                        expWr = alu[37];
                        expData = alu[31:0];
                        if (alu[36])
                            nextFlags = alu[35:32];
                    end
                end
                cpuPkg::DATA_REG: begin
                    if (op == cpuPkg::MUL || op == cpuPkg::MULS) begin
                        mulResult = regs[s1] * regs[s2];
                        mulDestM = d;
                        mulSignedM = (op == cpuPkg::MULS);
                        waitCnt = `MUL_CYCLES;
                        busy = 1;
                        if (mulSignedM)
                            nextFlags = 4'b0000;
                    end else begin
                        alu = refAlu(op, regs[s1], regs[s2]);
                        expWr = alu[37];
                        expData = alu[31:0];
                        if (alu[36])
                            nextFlags = alu[35:32];
                    end
                end
                cpuPkg::MEMORY: begin
                    expMemAddr = regs[s1] + immX;
                    expSt = fn[0];
                    expRd = !fn[0];
                    expWr = !fn[0];
                    expData = mem.exists(expMemAddr) ? mem[expMemAddr] : memDataIn;
                end
                default: begin
                    isBranch = 1;
                    expBr = (op == cpuPkg::BEQ && mFlags[2]) ||
                            (op == cpuPkg::BNE && !mFlags[2]) ||
                            (op == cpuPkg::BMI && mFlags[3]);
                end
            endcase
            expAddr = d;
        end
        compare("regWrite", {31'b0, regWrite}, {31'b0, expWr});
        if (expWr) begin
            compare("regWriteAddr", {28'b0, regWriteAddr}, {28'b0, expAddr});
            compare("regWriteData", regWriteData, expData);
        end
        compare("memRead", {31'b0, memRead}, {31'b0, expRd});
        compare("memWrite", {31'b0, memWrite}, {31'b0, expSt});
        if (expRd || expSt)
            compare("memAddr", memAddr, expMemAddr);
        if (expSt) begin
            compare("memDataOut", memDataOut, regs[d]);
            mem[expMemAddr] = regs[d];
        end
        compare("branchTaken", {31'b0, branchTaken}, {31'b0, expBr});
        if (isBranch)
            compare("branchOffset", {16'b0, branchOffset}, {16'b0, instr[15:0]});
        compare("flags", {28'b0, flags}, {28'b0, mFlags});
        if (expWr)
            regs[expAddr] = expData;
        mFlags = nextFlags;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++)
                regs[i] = '0;
            mFlags = 4'b0000;
            busy = 0;
            waitCnt = 0;
            mulDestM = '0;
            mulSignedM = 0;
            mulResult = '0;
        end else begin
            step();
        end
    end

endmodule

// File: dv/cpuCoreTb.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module cpuCoreTb;

    localparam int TOTAL_INSTR = 360;   // Upper bound over all tests
    localparam longint WATCH_NS = longint'(TOTAL_INSTR + 20) * (`MUL_CYCLES + 4) * 4;

    logic                       clk;
    logic                       rst;
    logic [`INSTR_WIDTH-1:0]    instr;
    logic                       issue;
    logic [`DATA_WIDTH-1:0]     memDataIn;
    logic                       ready;
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
    logic [`DATA_WIDTH-1:0]     regWriteData;
    logic [3:0]                 flags;
    logic                       branchTaken;
    logic [`IMM_WIDTH-1:0]      branchOffset;
    logic                       memRead;
    logic                       memWrite;
    logic [`DATA_WIDTH-1:0]     memAddr;
    logic [`DATA_WIDTH-1:0]     memDataOut;
    int                         errorCount;
    int                         errBefore;
    int                         testCount;
    logic                       hangFail;
    logic [31:0]                rndState;
    logic [31:0]                dataMem [256];
    logic [6:0]                 offsets [$];

    cpuCoreTop u_dut (.*);
    cpuCoreChecker u_chk (.*);

    initial begin
        clk = 0;
        forever #2 clk = ~clk;
    end

    // One word per address, small address window
    assign memDataIn = dataMem[memAddr[7:0]];
    always @(posedge clk) begin
        if (memWrite)
            dataMem[memAddr[7:0]] <= memDataOut;
    end

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rndState = xorshift(rndState);
        return rndState;
    endfunction

    function automatic logic [39:0] makeInstr(input logic [1:0] lvl, input logic sp,
                                              input logic [3:0] op, input logic [2:0] fn,
                                              input logic [3:0] d, input logic [3:0] s1,
                                              input logic [3:0] s2, input logic [15:0] imm);
        return {lvl, sp, op, fn, d, s1, s2, 2'b00, imm};
    endfunction

    task automatic sendInstr(input logic [39:0] word);
        int waited;
        waited = 0;
        while (!ready && !hangFail) begin   // Hold off while multiplying
            @(negedge clk);
            waited++;
            if (waited > `MUL_CYCLES + 8) begin
                $display("Core stayed busy too long, ready never returned");
                hangFail = 1;
            end
        end
        instr = word;
        issue = 1;
        @(negedge clk);
        issue = 0;
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("test %s: %0d errors", name, errorCount - errBefore);
        errBefore = errorCount;
    endtask

    task automatic runAlu(input int count);
        logic [3:0]  ops [5];
        logic [31:0] r;
        logic [3:0]  op;
        ops = '{cpuPkg::ADD, cpuPkg::SUB, cpuPkg::ADDS, cpuPkg::SUBS, cpuPkg::NOT};
        for (int i = 0; i < count; i++) begin
            r = nextRand();
            op = ops[r[31:29] % 5];
            if (r[0])
                sendInstr(makeInstr(cpuPkg::DATA_REG, 0, op, 0, r[4:1], r[8:5], r[12:9], 0));
            else
                sendInstr(makeInstr(cpuPkg::DATA_IMM, 1, (op == cpuPkg::NOT) ? 4'(cpuPkg::ADDS)
                          : op, 0, r[4:1], r[8:5], 0, r[28:13]));
        end
    endtask

    initial begin
        logic [31:0] r;
        rndState = 32'h4fe1;
        hangFail = 0;
        testCount = 0;
        errBefore = 0;
        instr = '0;
        issue = 0;
        for (int i = 0; i < 256; i++)
            dataMem[i] <= (i * 32'h9e3779b9) ^ {i[7:0], 24'h5a3c11};
        rst = 1;
        repeat (10) @(negedge clk);
        rst = 0;
        @(negedge clk);

        for (int d = 0; d < 16; d++)   // Load every register
            sendInstr(makeInstr(cpuPkg::DATA_IMM, 0, 0, cpuPkg::MOV, d, 0, 0, nextRand()));
        for (int i = 0; i < 4; i++)
            sendInstr(makeInstr(cpuPkg::DATA_IMM, 0, 0, cpuPkg::CLR, nextRand(), 0, 0, 0));
        endTest("resetAndMoves");

        runAlu(200);
        endTest("aluRandom");

        sendInstr(makeInstr(cpuPkg::DATA_IMM, 0, 0, cpuPkg::MOV, 1, 0, 0, nextRand() & 'h7f));
        for (int i = 0; i < 20; i++) begin
            r = nextRand();
            offsets.push_back(r[6:0]);
            sendInstr(makeInstr(cpuPkg::MEMORY, 0, 0, 3'b001, 2 + r[10:7] % 14, 1, 0,
                                {9'b0, r[6:0]}));
        end
        foreach (offsets[i])   // Same base register, same offsets
            sendInstr(makeInstr(cpuPkg::MEMORY, 0, 0, 3'b000, 2 + nextRand() % 14, 1, 0,
                                {9'b0, offsets[i]}));
        endTest("memory");

        for (int i = 0; i < 30; i++) begin
            r = nextRand();
            sendInstr(makeInstr(cpuPkg::DATA_REG, 0, cpuPkg::SUBS, 0, r[3:0], r[7:4],
                                r[8] ? r[7:4] : r[11:8], 0));
            sendInstr(makeInstr(cpuPkg::BRANCH, 0, (r[13:12] == 0) ? 4'(cpuPkg::BEQ) :
                                (r[13:12] == 1) ? 4'(cpuPkg::BNE) : 4'(cpuPkg::BMI),
                                0, 0, 0, 0, r[31:16]));
        end
        endTest("branches");

        for (int i = 0; i < 12; i++) begin
            r = nextRand();
            sendInstr(makeInstr(cpuPkg::DATA_REG, 0, r[0] ? 4'(cpuPkg::MULS) : 4'(cpuPkg::MUL),
                                0, r[4:1], r[8:5], r[12:9], 0));
            instr = makeInstr(cpuPkg::DATA_REG, 0, cpuPkg::ADDS, 0, r[16:13], r[20:17],
                              r[24:21], 0);
            issue = 1;   // Lands while ready is low
            @(negedge clk);
            issue = 0;
        end
        sendInstr(makeInstr(cpuPkg::DATA_IMM, 0, 0, cpuPkg::CLR, 0, 0, 0, 0));
        endTest("multiply");

        @(negedge clk);
        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0 && !hangFail)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: verilog/cpuCoreTop.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module cpuCoreTop (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic                       issue,
    input  logic [`DATA_WIDTH-1:0]     memDataIn,
    output logic                       ready,
    output logic                       regWrite,
    output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
    output logic [`DATA_WIDTH-1:0]     regWriteData,
    output logic [3:0]                 flags,
    output logic                       branchTaken,
    output logic [`IMM_WIDTH-1:0]      branchOffset,
    output logic                       memRead,
    output logic                       memWrite,
    output logic [`DATA_WIDTH-1:0]     memAddr,
    output logic [`DATA_WIDTH-1:0]     memDataOut
);

    cpuPkg::levelT              level;
    logic                       special;
    logic [3:0]                 op;
    logic [2:0]                 aluFn;
    logic [`REG_ADDR_WIDTH-1:0] dest, src1, src2, mulDest;
    logic [`REG_ADDR_WIDTH-1:0] readRegDest, readRegFirst, readRegSec;
    logic [`IMM_WIDTH-1:0]      imm;
    logic                       execValid, mulStart, mulSigned, mulRelease;
    logic [`DATA_WIDTH-1:0]     mulProduct;
    logic [3:0]                 mulFlags;
    logic [`DATA_WIDTH-1:0]     readDataDest, readDataFirst, readDataSec;

    issueControl u_issue (
        .clk, .rst, .instr, .issue, .ready, .level, .special, .op, .aluFn,
        .dest, .src1, .src2, .imm, .execValid, .mulStart, .mulSigned, .mulDest,
        .mulRelease
    );

    // Operands arrive on the same read ports as ALU sources
    mulUnit u_mul (
        .clk, .rst, .mulStart, .mulSigned, .opA(readDataFirst), .opB(readDataSec),
        .mulRelease, .mulProduct, .mulFlags
    );

    regFile u_regs (
        .clk, .rst, .readRegDest, .readRegFirst, .readRegSec,
        .writeEn(regWrite), .writeAddr(regWriteAddr), .writeData(regWriteData),
        .readDataDest, .readDataFirst, .readDataSec
    );

    execute u_exec (
        .clk, .rst, .execValid, .level, .special, .op, .aluFn, .dest, .src1, .src2,
        .imm, .readDataDest, .readDataFirst, .readDataSec, .memDataIn, .mulRelease,
        .mulProduct, .mulFlags, .mulDest, .mulSigned, .readRegDest, .readRegFirst,
        .readRegSec, .writeToReg(regWrite), .writeAddr(regWriteAddr),
        .writeData(regWriteData), .flags, .exeOverride(branchTaken),
        .exeData(branchOffset), .memAddr, .memDataOut, .memRead, .memWrite
    );

endmodule

// File: verilog/cpuCore_defs.svh
`ifndef CPUCORE_DEFS_SVH
`define CPUCORE_DEFS_SVH

// Datapath and register file sizes
`define DATA_WIDTH      32
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4
`define INSTR_WIDTH     40
`define IMM_WIDTH       16

// Instruction word fields
`define LEVEL_MSB       39
`define LEVEL_LSB       38
`define SPECIAL_BIT     37
`define OP_MSB          36   // Second-level decode or branch condition
`define OP_LSB          33
`define ALUFN_MSB       32
`define ALUFN_LSB       30
`define DEST_MSB        29
`define DEST_LSB        26
`define SRC1_MSB        25
`define SRC1_LSB        22
`define SRC2_MSB        21
`define SRC2_LSB        18
`define IMM_MSB         15
`define IMM_LSB         0

`define MUL_CYCLES      32   // One iteration per multiplier bit

`endif

// File: verilog/cpuPkg.sv
package cpuPkg;

    // Instruction class in the top two bits
    typedef enum logic [1:0] {
        DATA_IMM = 2'b00,
        DATA_REG = 2'b01,
        MEMORY   = 2'b10,
        BRANCH   = 2'b11
    } levelT;

    // Second-level decode of data instructions
    typedef enum logic [3:0] {
        MUL  = 4'b0000,
        ADD  = 4'b0001,
        SUB  = 4'b0010,
        NOT  = 4'b0110,
        MULS = 4'b1000,
        ADDS = 4'b1001,
        SUBS = 4'b1010
    } aluOpT;

    // Branch conditions, carried in the op field
    typedef enum logic [3:0] {
        BEQ = 4'b0000,
        BNE = 4'b0001,
        BMI = 4'b0100
    } branchT;

    // Move functions, carried in aluFn when special is clear
    typedef enum logic [2:0] {
        MOV = 3'b000,
        CLR = 3'b010
    } movFnT;

    // Bit positions in the NZCV vector
    typedef enum int unsigned {
        FLAG_V = 0,
        FLAG_C = 1,
        FLAG_Z = 2,
        FLAG_N = 3
    } flagIdx;

endpackage

// File: verilog/execute.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module execute (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       execValid,
    input  cpuPkg::levelT              level,
    input  logic                       special,
    input  logic [3:0]                 op,
    input  logic [2:0]                 aluFn,
    input  logic [`REG_ADDR_WIDTH-1:0] dest,
    input  logic [`REG_ADDR_WIDTH-1:0] src1,
    input  logic [`REG_ADDR_WIDTH-1:0] src2,
    input  logic [`IMM_WIDTH-1:0]      imm,
    input  logic [`DATA_WIDTH-1:0]     readDataDest,
    input  logic [`DATA_WIDTH-1:0]     readDataFirst,
    input  logic [`DATA_WIDTH-1:0]     readDataSec,
    input  logic [`DATA_WIDTH-1:0]     memDataIn,
    input  logic                       mulRelease,
    input  logic [`DATA_WIDTH-1:0]     mulProduct,
    input  logic [3:0]                 mulFlags,
    input  logic [`REG_ADDR_WIDTH-1:0] mulDest,
    input  logic                       mulSigned,
    output logic [`REG_ADDR_WIDTH-1:0] readRegDest,
    output logic [`REG_ADDR_WIDTH-1:0] readRegFirst,
    output logic [`REG_ADDR_WIDTH-1:0] readRegSec,
    output logic                       writeToReg,
    output logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    output logic [`DATA_WIDTH-1:0]     writeData,
    output logic [3:0]                 flags,
    output logic                       exeOverride,
    output logic [`IMM_WIDTH-1:0]      exeData,
    output logic [`DATA_WIDTH-1:0]     memAddr,
    output logic [`DATA_WIDTH-1:0]     memDataOut,
    output logic                       memRead,
    output logic                       memWrite
);

    localparam int MSB = `DATA_WIDTH - 1;

    logic [3:0]         flagsNext;
    logic [MSB:0]       immExt;
    logic [MSB:0]       opB;
    logic [`DATA_WIDTH:0] sumExt;
    logic [`DATA_WIDTH:0] diffExt;
    logic [MSB:0]       aluResult;
    logic [3:0]         aluFlags;
    logic               aluValid;
    logic               aluSetFlags;

    // Operand registers follow the instruction fields directly
    assign readRegDest  = dest;   // Store data
    assign readRegFirst = src1;
    assign readRegSec   = src2;

    assign exeData = imm;   // Branch offset
    assign immExt  = {{(`DATA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
    assign opB     = (level == cpuPkg::DATA_IMM) ? immExt : readDataSec;
    assign sumExt  = {1'b0, readDataFirst} + {1'b0, opB};
    assign diffExt = {1'b0, readDataFirst} - {1'b0, opB};

    // Shared ALU for both operand forms
    always_comb begin
        aluResult   = '0;
        aluFlags    = flags;
        aluValid    = 1'b0;
        aluSetFlags = (op == cpuPkg::ADDS) || (op == cpuPkg::SUBS);
        case (op)
            cpuPkg::ADD, cpuPkg::ADDS: begin
                aluValid  = 1'b1;
                aluResult = sumExt[MSB:0];
                aluFlags[cpuPkg::FLAG_C] = sumExt[`DATA_WIDTH];
                aluFlags[cpuPkg::FLAG_V] = ~(readDataFirst[MSB] ^ opB[MSB]) &
                                           (readDataFirst[MSB] ^ aluResult[MSB]);
            end
            cpuPkg::SUB, cpuPkg::SUBS: begin
                aluValid  = 1'b1;
                aluResult = diffExt[MSB:0];
                aluFlags[cpuPkg::FLAG_C] = ~diffExt[`DATA_WIDTH];   // Not borrow
                aluFlags[cpuPkg::FLAG_V] = (readDataFirst[MSB] ^ opB[MSB]) &
                                           (readDataFirst[MSB] ^ aluResult[MSB]);
            end
            cpuPkg::NOT: begin
                aluValid  = 1'b1;
                aluResult = ~readDataFirst;
            end
            default: aluValid = 1'b0;
        endcase
        aluFlags[cpuPkg::FLAG_N] = aluResult[MSB];
        aluFlags[cpuPkg::FLAG_Z] = (aluResult == '0);
    end

    always_comb begin
        writeToReg  = 1'b0;
        writeAddr   = dest;
        writeData   = '0;
        flagsNext   = flags;
        exeOverride = 1'b0;
        memAddr     = '0;
        memDataOut  = '0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        if (mulRelease) begin
            // Multiplier writeback, never alongside an issue
            writeToReg = 1'b1;
            writeAddr  = mulDest;
            writeData  = mulProduct;
            flagsNext  = flags | (mulSigned ? mulFlags : 4'b0000);
        end else if (execValid) begin
            case (level)
                cpuPkg::DATA_IMM: begin
                    if (!special) begin
                        case (aluFn)
                            cpuPkg::MOV: begin
                                writeToReg = 1'b1;
                                writeData  = immExt;
                            end
                            cpuPkg::CLR: writeToReg = 1'b1;   // Writes zero
                            default: writeToReg = 1'b0;
                        endcase
                    end else if (aluValid && op != cpuPkg::NOT) begin
                        writeToReg = 1'b1;
                        writeData  = aluResult;
                        if (aluSetFlags)
                            flagsNext = aluFlags;
                    end
                end
                cpuPkg::DATA_REG: begin
                    if (op == cpuPkg::MULS) begin
                        flagsNext = 4'b0000;   // Rebuilt from the product on release
                    end else if (aluValid) begin
                        writeToReg = 1'b1;
                        writeData  = aluResult;
                        if (aluSetFlags)
                            flagsNext = aluFlags;
                    end
                end
                cpuPkg::MEMORY: begin
                    memAddr = readDataFirst + immExt;
                    if (aluFn[0]) begin
                        memWrite   = 1'b1;
                        memDataOut = readDataDest;
                    end else begin
                        memRead    = 1'b1;
                        writeToReg = 1'b1;
                        writeData  = memDataIn;
                    end
                end
                cpuPkg::BRANCH: begin
                    case (op)
                        cpuPkg::BEQ: exeOverride = flags[cpuPkg::FLAG_Z];
                        cpuPkg::BNE: exeOverride = !flags[cpuPkg::FLAG_Z];
                        cpuPkg::BMI: exeOverride = flags[cpuPkg::FLAG_N];
                        default:     exeOverride = 1'b0;
                    endcase
                end
                default: writeToReg = 1'b0;
            endcase
        end
    end

    // NZCV register
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            flags <= 4'b0000;
        else
            flags <= flagsNext;
    end

    // An issue in the release cycle would be lost behind the writeback
    assert property (@(posedge clk) disable iff (rst) mulRelease |-> !execValid);

endmodule

// File: verilog/issueControl.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module issueControl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic                       issue,
    output logic                       ready,
    output cpuPkg::levelT              level,
    output logic                       special,
    output logic [3:0]                 op,
    output logic [2:0]                 aluFn,
    output logic [`REG_ADDR_WIDTH-1:0] dest,
    output logic [`REG_ADDR_WIDTH-1:0] src1,
    output logic [`REG_ADDR_WIDTH-1:0] src2,
    output logic [`IMM_WIDTH-1:0]      imm,
    output logic                       execValid,
    output logic                       mulStart,
    output logic                       mulSigned,
    output logic [`REG_ADDR_WIDTH-1:0] mulDest,
    input  logic                       mulRelease
);

    typedef enum logic {
        IDLE,
        MULWAIT
    } stateT;

    stateT state;
    logic  isMul;

    // Field slicing straight from the instruction word
    assign level   = cpuPkg::levelT'(instr[`LEVEL_MSB:`LEVEL_LSB]);
    assign special = instr[`SPECIAL_BIT];
    assign op      = instr[`OP_MSB:`OP_LSB];
    assign aluFn   = instr[`ALUFN_MSB:`ALUFN_LSB];
    assign dest    = instr[`DEST_MSB:`DEST_LSB];
    assign src1    = instr[`SRC1_MSB:`SRC1_LSB];
    assign src2    = instr[`SRC2_MSB:`SRC2_LSB];
    assign imm     = instr[`IMM_MSB:`IMM_LSB];

    // Multiplies only exist in register form
    assign isMul = (level == cpuPkg::DATA_REG) &&
                   (op == cpuPkg::MUL || op == cpuPkg::MULS);

    assign ready     = (state == IDLE);
    assign execValid = issue && ready;   // Issue while busy is dropped
    assign mulStart  = execValid && isMul;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            mulSigned <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (mulStart) begin
                        state     <= MULWAIT;
                        mulSigned <= (op == cpuPkg::MULS);
                    end
                end
                MULWAIT: begin
                    if (mulRelease)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Destination held for the write on release
    always_ff @(posedge clk) begin
        if (mulStart)
            mulDest <= dest;
    end

    // Multiplier must not finish unless this FSM is waiting on it
    assert property (@(posedge clk) disable iff (rst) mulRelease |-> state == MULWAIT);

endmodule

// File: verilog/mulUnit.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module mulUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mulStart,
    input  logic                   mulSigned,
    input  logic [`DATA_WIDTH-1:0] opA,
    input  logic [`DATA_WIDTH-1:0] opB,
    output logic                   mulRelease,
    output logic [`DATA_WIDTH-1:0] mulProduct,
    output logic [3:0]             mulFlags
);

    localparam int CNT_WIDTH = $clog2(`MUL_CYCLES);
    localparam logic [CNT_WIDTH-1:0] LAST_ITER = CNT_WIDTH'(`MUL_CYCLES - 1);

    logic                   busy;
    logic [CNT_WIDTH-1:0]   iterCount;
    logic [`DATA_WIDTH-1:0] multiplicand;
    logic [`DATA_WIDTH-1:0] multiplier;
    logic [`DATA_WIDTH-1:0] acc;

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            iterCount  <= '0;
            mulRelease <= 1'b0;
        end else begin
            mulRelease <= 1'b0;
            if (mulStart) begin
                busy      <= 1'b1;
                iterCount <= '0;
            end else if (busy) begin
                iterCount <= iterCount + 1'b1;
                if (iterCount == LAST_ITER) begin
                    busy       <= 1'b0;
                    mulRelease <= 1'b1;   // Product settles at this edge
                end
            end
        end
    end

    // Shift-add datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (mulStart) begin
            multiplicand <= opA;
            multiplier   <= opB;
            acc          <= '0;
        end else if (busy) begin
            if (multiplier[0])
                acc <= acc + multiplicand;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    assign mulProduct = acc;

    // N and Z only for the flag-setting form
    always_comb begin
        mulFlags = 4'b0000;
        if (mulSigned) begin
            mulFlags[cpuPkg::FLAG_N] = acc[`DATA_WIDTH-1];
            mulFlags[cpuPkg::FLAG_Z] = (acc == '0);
        end
    end

    assert property (@(posedge clk) disable iff (rst) mulStart |-> !busy);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "cpuCore_defs.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] readRegDest,
    input  logic [`REG_ADDR_WIDTH-1:0] readRegFirst,
    input  logic [`REG_ADDR_WIDTH-1:0] readRegSec,
    input  logic                       writeEn,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]     readDataDest,
    output logic [`DATA_WIDTH-1:0]     readDataFirst,
    output logic [`DATA_WIDTH-1:0]     readDataSec
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see the value before this cycle's write
    assign readDataDest  = regs[readRegDest];
    assign readDataFirst = regs[readRegFirst];
    assign readDataSec   = regs[readRegSec];

endmodule
